// ==== hw/gpt_reg_pkg.sv ====
package gpt_reg_pkg;

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Register map
  localparam reg_addr_t ADDR_CR1   = 8'h00;
  localparam reg_addr_t ADDR_CR2   = 8'h04;
  localparam reg_addr_t ADDR_DIER  = 8'h0C;
  localparam reg_addr_t ADDR_SR    = 8'h10;
  localparam reg_addr_t ADDR_EGR   = 8'h14;
  localparam reg_addr_t ADDR_CCMR1 = 8'h18;
  localparam reg_addr_t ADDR_CCMR2 = 8'h1C;
  localparam reg_addr_t ADDR_CCER  = 8'h20;
  localparam reg_addr_t ADDR_CNT   = 8'h24;
  localparam reg_addr_t ADDR_PSC   = 8'h28;
  localparam reg_addr_t ADDR_ARR   = 8'h2C;
  localparam reg_addr_t ADDR_CCR1  = 8'h34;
  localparam reg_addr_t ADDR_CCR2  = 8'h38;
  localparam reg_addr_t ADDR_CCR3  = 8'h3C;
  localparam reg_addr_t ADDR_CCR4  = 8'h40;

  // Bit positions
  localparam int CR1_CEN          = 0;
  localparam int CR1_OPM          = 3;
  localparam int CR1_DIR          = 4;
  localparam int CR1_APRE         = 7;
  localparam int CR2_MMS_LSB      = 4;
  // DIER uses the same layout as SR
  localparam int SR_UIF           = 0;
  localparam int SR_CC1IF         = 1;
  localparam int EGR_UG           = 0;
  localparam int CCMR_OC_EVEN_LSB = 4;
  localparam int CCMR_OC_ODD_LSB  = 12;
  localparam int CCER_STRIDE      = 4;
  localparam int CCER_POL_OFS     = 1;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    reg_addr_t paddr;
    reg_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    reg_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

// ==== hw/gpt_tim_pkg.sv ====
package gpt_tim_pkg;

  typedef logic [31:0] cnt_t;
  typedef logic [15:0] psc_t;

  typedef enum logic [2:0] {
    OC_FROZEN     = 3'd0,
    OC_ACTIVE     = 3'd1,
    OC_INACTIVE   = 3'd2,
    OC_TOGGLE     = 3'd3,
    OC_FORCE_LOW  = 3'd4,
    OC_FORCE_HIGH = 3'd5,
    OC_PWM1       = 3'd6,
    OC_PWM2       = 3'd7
  } oc_mode_e;

  // Source of the master trigger
  typedef enum logic [1:0] {
    MMS_UPDATE = 2'd0,
    MMS_ENABLE = 2'd1,
    MMS_OC1REF = 2'd2
  } mms_e;

  typedef struct packed {
    logic cen;
    logic dir;
    // Single-cycle software update request
    logic ug;
    logic apre;
    psc_t psc;
    cnt_t arr;
  } tb_cfg_t;

  typedef struct packed {
    oc_mode_e mode;
    logic     cc_en;
    logic     cc_pol;
    cnt_t     ccr;
  } oc_cfg_t;

endpackage

// ==== hw/gpt_apb_regs.sv ====
`timescale 1ns/1ps

module gpt_apb_regs #(
  parameter int CH_NUM = 4
) (
  input  logic                  aclk_i,
  input  logic                  reset_i,
  input  gpt_reg_pkg::apb_req_t apb_req_i,
  output gpt_reg_pkg::apb_rsp_t apb_rsp_o,
  input  gpt_tim_pkg::cnt_t     cnt_i,
  input  logic                  uev_i,
  input  logic [CH_NUM-1:0]     match_i,
  output gpt_tim_pkg::tb_cfg_t  tb_cfg_o,
  output gpt_tim_pkg::oc_cfg_t  oc_cfg_o [CH_NUM],
  output gpt_tim_pkg::mms_e     mms_o,
  output logic                  irq_o
);
  import gpt_reg_pkg::*;
  import gpt_tim_pkg::*;

  logic              cen_q;
  logic              opm_q;
  logic              dir_q;
  logic              apre_q;
  mms_e              mms_q;
  logic [CH_NUM:0]   dier_q;
  logic [CH_NUM:0]   sr_q;
  psc_t              psc_q;
  cnt_t              arr_q;
  oc_mode_e          mode_q [CH_NUM];
  logic [CH_NUM-1:0] cc_en_q;
  logic [CH_NUM-1:0] cc_pol_q;
  cnt_t              ccr_q [CH_NUM];
  logic              ug_q;
  logic              irq_q;

  logic              access;
  logic              wr_en;
  logic              addr_hit;
  reg_data_t         rdata;
  logic [CH_NUM:0]   sr_keep;
  logic [CH_NUM:0]   sr_set;

  // Two channels per CCMR register
  function automatic reg_addr_t ccmr_addr(int idx);
    return (idx < 2) ? ADDR_CCMR1 : ADDR_CCMR2;
  endfunction

  function automatic int ccmr_lsb(int idx);
    return (idx % 2 == 0) ? CCMR_OC_EVEN_LSB : CCMR_OC_ODD_LSB;
  endfunction

  function automatic reg_addr_t ccr_addr(int idx);
    return ADDR_CCR1 + reg_addr_t'(4 * idx);
  endfunction

  assign access = apb_req_i.psel && apb_req_i.penable;
  assign wr_en  = access && apb_req_i.pwrite && addr_hit;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (apb_req_i.paddr)
      ADDR_CR1: begin
        rdata[CR1_CEN]  = cen_q;
        rdata[CR1_OPM]  = opm_q;
        rdata[CR1_DIR]  = dir_q;
        rdata[CR1_APRE] = apre_q;
      end
      ADDR_CR2:  rdata[CR2_MMS_LSB +: $bits(mms_e)] = mms_q;
      ADDR_DIER: rdata[CH_NUM:0] = dier_q;
      ADDR_SR:   rdata[CH_NUM:0] = sr_q;
      ADDR_EGR:  rdata = '0;
      ADDR_CCER: begin
        for (int i = 0; i < CH_NUM; i++) begin
          rdata[CCER_STRIDE * i]                = cc_en_q[i];
          rdata[CCER_STRIDE * i + CCER_POL_OFS] = cc_pol_q[i];
        end
      end
      ADDR_CNT:  rdata = cnt_i;
      ADDR_PSC:  rdata[$bits(psc_t)-1:0] = psc_q;
      ADDR_ARR:  rdata = arr_q;
      default: begin
        // CCMR and CCR exist only for implemented channels
        addr_hit = 1'b0;
        for (int i = 0; i < CH_NUM; i++) begin
          if (apb_req_i.paddr == ccmr_addr(i)) begin
            addr_hit = 1'b1;
            rdata[ccmr_lsb(i) +: $bits(oc_mode_e)] = mode_q[i];
          end
          if (apb_req_i.paddr == ccr_addr(i)) begin
            addr_hit = 1'b1;
            rdata    = ccr_q[i];
          end
        end
      end
    endcase
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access && !addr_hit;

  // Zeros written to SR clear bits unless hardware sets them
  assign sr_keep = (wr_en && apb_req_i.paddr == ADDR_SR) ? apb_req_i.pwdata[CH_NUM:0] : '1;

  always_comb begin
    sr_set                      = '0;
    sr_set[SR_UIF]              = uev_i;
    sr_set[SR_CC1IF +: CH_NUM]  = match_i;
  end

  always_ff @(posedge aclk_i) begin
    if (reset_i) begin
      cen_q    <= 1'b0;
      opm_q    <= 1'b0;
      dir_q    <= 1'b0;
      apre_q   <= 1'b0;
      mms_q    <= MMS_UPDATE;
      dier_q   <= '0;
      sr_q     <= '0;
      psc_q    <= '0;
      arr_q    <= '1;
      cc_en_q  <= '0;
      cc_pol_q <= '0;
      ug_q     <= 1'b0;
      irq_q    <= 1'b0;
      for (int i = 0; i < CH_NUM; i++) begin
        mode_q[i] <= OC_FROZEN;
        ccr_q[i]  <= '0;
      end
    end else begin
      ug_q  <= wr_en && (apb_req_i.paddr == ADDR_EGR) && apb_req_i.pwdata[EGR_UG];
      sr_q  <= (sr_q & sr_keep) | sr_set;
      irq_q <= |(sr_q & dier_q);
      // One-pulse mode stops the counter at the update
      if (uev_i && opm_q) begin
        cen_q <= 1'b0;
      end
      if (wr_en) begin
        case (apb_req_i.paddr)
          ADDR_CR1: begin
            cen_q  <= apb_req_i.pwdata[CR1_CEN];
            opm_q  <= apb_req_i.pwdata[CR1_OPM];
            dir_q  <= apb_req_i.pwdata[CR1_DIR];
            apre_q <= apb_req_i.pwdata[CR1_APRE];
          end
          ADDR_CR2:  mms_q  <= mms_e'(apb_req_i.pwdata[CR2_MMS_LSB +: $bits(mms_e)]);
          ADDR_DIER: dier_q <= apb_req_i.pwdata[CH_NUM:0];
          ADDR_PSC:  psc_q  <= apb_req_i.pwdata[$bits(psc_t)-1:0];
          ADDR_ARR:  arr_q  <= apb_req_i.pwdata;
          ADDR_CCER: begin
            for (int i = 0; i < CH_NUM; i++) begin
              cc_en_q[i]  <= apb_req_i.pwdata[CCER_STRIDE * i];
              cc_pol_q[i] <= apb_req_i.pwdata[CCER_STRIDE * i + CCER_POL_OFS];
            end
          end
          default: begin
            for (int i = 0; i < CH_NUM; i++) begin
              if (apb_req_i.paddr == ccmr_addr(i)) begin
                mode_q[i] <= oc_mode_e'(apb_req_i.pwdata[ccmr_lsb(i) +: $bits(oc_mode_e)]);
              end
              if (apb_req_i.paddr == ccr_addr(i)) begin
                ccr_q[i] <= apb_req_i.pwdata;
              end
            end
          end
        endcase
      end
    end
  end

  assign tb_cfg_o = '{cen: cen_q, dir: dir_q, ug: ug_q, apre: apre_q, psc: psc_q, arr: arr_q};

  always_comb begin
    for (int i = 0; i < CH_NUM; i++) begin
      oc_cfg_o[i] = '{mode: mode_q[i], cc_en: cc_en_q[i], cc_pol: cc_pol_q[i], ccr: ccr_q[i]};
    end
  end

  assign mms_o = mms_q;
  assign irq_o = irq_q;

  // Error response only in an access cycle that follows a setup cycle
  assert property (@(posedge aclk_i) disable iff (reset_i)
    apb_rsp_o.pslverr |-> $past(apb_req_i.psel && !apb_req_i.penable));

  // APB never issues two access cycles back to back
  assert property (@(posedge aclk_i) disable iff (reset_i) ug_q |=> !ug_q);

endmodule

// ==== hw/gpt_time_base.sv ====
`timescale 1ns/1ps

module gpt_time_base (
  input  logic                 aclk_i,
  input  logic                 reset_i,
  input  gpt_tim_pkg::tb_cfg_t cfg_i,
  output gpt_tim_pkg::cnt_t    cnt_o,
  output logic                 uev_o
);
  import gpt_tim_pkg::*;

  psc_t psc_cnt;
  psc_t psc_shadow;
  cnt_t arr_shadow;
  cnt_t arr_eff;
  cnt_t cnt_q;
  logic tick;
  logic wrap;

  // Without APRE a new ARR applies at once
  assign arr_eff = cfg_i.apre ? arr_shadow : cfg_i.arr;

  assign tick  = cfg_i.cen && (psc_cnt == psc_shadow);
  assign wrap  = cfg_i.dir ? (cnt_q == '0) : (cnt_q >= arr_eff);
  assign uev_o = cfg_i.ug || (tick && wrap);
  assign cnt_o = cnt_q;

  // Prescaler and shadow registers
  always_ff @(posedge aclk_i) begin
    if (reset_i) begin
      psc_cnt    <= '0;
      psc_shadow <= '0;
      arr_shadow <= '1;
    end else begin
      if (cfg_i.ug || tick) begin
        psc_cnt <= '0;
      end else if (cfg_i.cen) begin
        psc_cnt <= psc_cnt + 1'b1;
      end
      if (uev_o) begin
        psc_shadow <= cfg_i.psc;
      end
      if (uev_o || !cfg_i.apre) begin
        arr_shadow <= cfg_i.arr;
      end
    end
  end

  // Main counter
  always_ff @(posedge aclk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (cfg_i.ug) begin
      cnt_q <= cfg_i.dir ? cfg_i.arr : '0;
    end else if (tick) begin
      if (cfg_i.dir) begin
        // Reload takes the value the shadow picks up at this update
        cnt_q <= wrap ? cfg_i.arr : cnt_q - 1'b1;
      end else begin
        cnt_q <= wrap ? '0 : cnt_q + 1'b1;
      end
    end
  end

  // Prescaler never counts past its shadow limit
  assert property (@(posedge aclk_i) disable iff (reset_i) psc_cnt <= psc_shadow);

endmodule

// ==== hw/gpt_oc_channel.sv ====
`timescale 1ns/1ps

module gpt_oc_channel (
  input  logic                 aclk_i,
  input  logic                 reset_i,
  input  gpt_tim_pkg::oc_cfg_t cfg_i,
  input  gpt_tim_pkg::cnt_t    cnt_i,
  input  logic                 dir_i,
  output logic                 match_o,
  output logic                 oc_ref_o,
  output logic                 ch_o
);
  import gpt_tim_pkg::*;

  logic eq;
  logic eq_q;
  logic pwm_on;
  logic oc_ref_q;

  assign eq      = (cnt_i == cfg_i.ccr);
  assign match_o = eq && !eq_q;

  // PWM1 level includes CCR itself when counting down
  assign pwm_on = dir_i ? (cnt_i <= cfg_i.ccr) : (cnt_i < cfg_i.ccr);

  always_ff @(posedge aclk_i) begin
    if (reset_i) begin
      // Counter and CCR both start at 0 so no match until it moves
      eq_q     <= 1'b1;
      oc_ref_q <= 1'b0;
    end else begin
      eq_q <= eq;
      case (cfg_i.mode)
        OC_ACTIVE:     oc_ref_q <= oc_ref_q | eq;
        OC_INACTIVE:   oc_ref_q <= oc_ref_q & !eq;
        OC_TOGGLE:     oc_ref_q <= oc_ref_q ^ match_o;
        OC_FORCE_LOW:  oc_ref_q <= 1'b0;
        OC_FORCE_HIGH: oc_ref_q <= 1'b1;
        OC_PWM1:       oc_ref_q <= pwm_on;
        OC_PWM2:       oc_ref_q <= !pwm_on;
        default:       oc_ref_q <= oc_ref_q;
      endcase
    end
  end

  assign oc_ref_o = oc_ref_q;
  assign ch_o     = cfg_i.cc_en && (oc_ref_q ^ cfg_i.cc_pol);

endmodule

// ==== hw/gpt_top.sv ====
`timescale 1ns/1ps

module gpt_top #(
  parameter int CH_NUM = 4
) (
  input  logic                  aclk_i,
  input  logic                  reset_i,
  input  gpt_reg_pkg::apb_req_t apb_req_i,
  output gpt_reg_pkg::apb_rsp_t apb_rsp_o,
  output logic [CH_NUM-1:0]     ch_o,
  output logic                  irq_o,
  output logic                  trg_o
);
  import gpt_tim_pkg::*;

  tb_cfg_t           tb_cfg;
  oc_cfg_t           oc_cfg [CH_NUM];
  mms_e              mms;
  cnt_t              cnt;
  logic              uev;
  logic [CH_NUM-1:0] match;
  logic [CH_NUM-1:0] oc_ref;
  logic              trg_q;

  gpt_apb_regs #(
    .CH_NUM (CH_NUM)
  ) regs_i (
    .aclk_i    (aclk_i),
    .reset_i   (reset_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .cnt_i     (cnt),
    .uev_i     (uev),
    .match_i   (match),
    .tb_cfg_o  (tb_cfg),
    .oc_cfg_o  (oc_cfg),
    .mms_o     (mms),
    .irq_o     (irq_o)
  );

  gpt_time_base time_base_i (
    .aclk_i  (aclk_i),
    .reset_i (reset_i),
    .cfg_i   (tb_cfg),
    .cnt_o   (cnt),
    .uev_o   (uev)
  );

  for (genvar i = 0; i < CH_NUM; i++) begin : g_ch
    gpt_oc_channel channel_i (
      .aclk_i   (aclk_i),
      .reset_i  (reset_i),
      .cfg_i    (oc_cfg[i]),
      .cnt_i    (cnt),
      .dir_i    (tb_cfg.dir),
      .match_o  (match[i]),
      .oc_ref_o (oc_ref[i]),
      .ch_o     (ch_o[i])
    );
  end

  // Master trigger
  always_ff @(posedge aclk_i) begin
    if (reset_i) begin
      trg_q <= 1'b0;
    end else begin
      case (mms)
        MMS_UPDATE: trg_q <= uev;
        MMS_ENABLE: trg_q <= tb_cfg.cen;
        MMS_OC1REF: trg_q <= oc_ref[0];
        default:    trg_q <= 1'b0;
      endcase
    end
  end

  assign trg_o = trg_q;

endmodule

// ==== tb/gpt_tb.sv ====
`timescale 1ns/1ps

module gpt_tb;
  import gpt_reg_pkg::*;
  import gpt_tim_pkg::*;

  localparam int CH_NUM   = 4;
  localparam int ROWS     = 6;
  localparam int KIND_PER = 0;
  localparam int KIND_PWM = 1;

  typedef struct {
    string    name;
    int       kind;
    int       psc;
    int       arr;
    logic     dir;
    oc_mode_e mode;
    int       ccr;
    logic     pol;
    logic     en;
    int       expected;
  } row_t;

  logic              aclk;
  logic              reset_i;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  logic [CH_NUM-1:0] ch;
  logic              irq;
  logic              trg;

  row_t              table_q [ROWS];
  logic              table_ready = 1'b0;
  logic [31:0]       lcg_state   = 32'h5c2d_4ca4;
  int                n_pass      = 0;
  int                n_fail      = 0;

  gpt_top #(
    .CH_NUM (CH_NUM)
  ) gpt_top_i (
    .aclk_i    (aclk),
    .reset_i   (reset_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .ch_o      (ch),
    .irq_o     (irq),
    .trg_o     (trg)
  );

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_data(string name, reg_data_t exp, reg_data_t act);
    if (exp === act) begin
      n_pass++;
      $display("[PASS] %s", name);
    end else begin
      n_fail++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp === act) begin
      n_pass++;
      $display("[PASS] %s", name);
    end else begin
      n_fail++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic apb_write(reg_addr_t addr, reg_data_t data);
    @(posedge aclk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge aclk);
    apb_req.penable <= 1'b1;
    @(posedge aclk);
    apb_req <= '0;
  endtask

  task automatic apb_read(reg_addr_t addr, output reg_data_t data, output logic err);
    @(posedge aclk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge aclk);
    apb_req.penable <= 1'b1;
    // Response is settled in the middle of the access cycle
    @(negedge aclk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    if (apb_rsp.pready !== 1'b1) begin
      n_fail++;
      $display("APB read at address %h did not complete in its access cycle", addr);
    end
    @(posedge aclk);
    apb_req <= '0;
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge aclk);
  endtask

  task automatic wait_trg();
    do @(negedge aclk); while (!trg);
  endtask

  // Stop, load PSC/ARR through UG, then start counting
  task automatic start_counter(int psc, int arr, logic dir, logic opm);
    apb_write(ADDR_CR1, '0);
    apb_write(ADDR_CR2, '0);
    apb_write(ADDR_PSC, reg_data_t'(psc));
    apb_write(ADDR_ARR, reg_data_t'(arr));
    apb_write(ADDR_EGR, 32'h1);
    apb_write(ADDR_CR1, (32'(dir) << CR1_DIR) | (32'(opm) << CR1_OPM) | 32'h1);
  endtask

  task automatic build_table();
    int period;
    int hi;
    table_q[0] = '{"period_up", KIND_PER, 2, 9, 1'b0, OC_FROZEN, 0, 1'b0, 1'b0, 0};
    table_q[1] = '{"period_down", KIND_PER, 1, 14, 1'b1, OC_FROZEN, 0, 1'b0, 1'b0, 0};
    table_q[2] = '{"pwm1_pol0", KIND_PWM, 1, 15, 1'b0, OC_PWM1, 0, 1'b0, 1'b1, 0};
    table_q[3] = '{"pwm1_pol1", KIND_PWM, 0, 19, 1'b0, OC_PWM1, 0, 1'b1, 1'b1, 0};
    table_q[4] = '{"pwm2_pol0", KIND_PWM, 2, 11, 1'b0, OC_PWM2, 0, 1'b0, 1'b1, 0};
    table_q[5] = '{"pwm1_disabled", KIND_PWM, 0, 9, 1'b0, OC_PWM1, 0, 1'b0, 1'b0, 0};
    for (int r = 0; r < ROWS; r++) begin
      period = (table_q[r].psc + 1) * (table_q[r].arr + 1);
      if (table_q[r].kind == KIND_PER) begin
        table_q[r].expected = period;
      end else begin
        table_q[r].ccr = int'(lcg_next() % 32'(table_q[r].arr + 1));
        if (table_q[r].mode == OC_PWM1) begin
          hi = table_q[r].ccr;
        end else begin
          hi = table_q[r].arr + 1 - table_q[r].ccr;
        end
        hi = 3 * (table_q[r].psc + 1) * hi;
        if (table_q[r].pol) begin
          hi = 3 * period - hi;
        end
        table_q[r].expected = table_q[r].en ? hi : 0;
      end
    end
    table_ready = 1'b1;
  endtask

  // PWM rows run on the given channel so every ch_o bit gets measured
  task automatic run_row(row_t row, int chan);
    int        n;
    int        period;
    reg_addr_t ccmr_addr;
    int        ccmr_lsb;
    period = (row.psc + 1) * (row.arr + 1);
    if (row.kind == KIND_PWM) begin
      ccmr_addr = (chan < 2) ? ADDR_CCMR1 : ADDR_CCMR2;
      ccmr_lsb  = (chan % 2 == 0) ? CCMR_OC_EVEN_LSB : CCMR_OC_ODD_LSB;
      apb_write(ccmr_addr, reg_data_t'(row.mode) << ccmr_lsb);
      apb_write(ADDR_CCR1 + reg_addr_t'(4 * chan), reg_data_t'(row.ccr));
      apb_write(ADDR_CCER,
                ((32'(row.pol) << CCER_POL_OFS) | 32'(row.en)) << (CCER_STRIDE * chan));
    end
    start_counter(row.psc, row.arr, row.dir, 1'b0);
    wait_trg();
    n = 0;
    if (row.kind == KIND_PER) begin
      do begin
        @(negedge aclk);
        n++;
      end while (!trg);
    end else begin
      repeat (3 * period) begin
        @(negedge aclk);
        n += int'(ch[chan]);
      end
    end
    check_data(row.name, reg_data_t'(row.expected), reg_data_t'(n));
  endtask

  // Watchdog sized from the table plus the directed tests
  initial begin
    int limit;
    wait (table_ready);
    limit = 3000;
    for (int r = 0; r < ROWS; r++) begin
      limit += 4 * (table_q[r].psc + 1) * (table_q[r].arr + 1) + 50;
    end
    repeat (limit) @(posedge aclk);
    $display("Timeout: simulation did not finish within %0d cycles", limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reg_data_t data;
    logic      err;
    int        pulses;
    apb_req = '0;
    reset_i = 1'b1;
    build_table();
    repeat (2) @(posedge aclk);
    reset_i <= 1'b0;

    // Register access
    apb_read(ADDR_ARR, data, err);
    check_data("arr_reset", 32'hffff_ffff, data);
    apb_write(ADDR_PSC, 32'h1234);
    apb_read(ADDR_PSC, data, err);
    check_data("psc_rw", 32'h1234, data);
    apb_write(ADDR_CCR2, 32'hdead_beef);
    apb_read(ADDR_CCR2, data, err);
    check_data("ccr2_rw", 32'hdead_beef, data);
    apb_write(ADDR_CR2, 32'h20);
    apb_read(ADDR_CR2, data, err);
    check_data("cr2_rw", 32'h20, data);
    apb_write(ADDR_CR2, '0);
    apb_read(ADDR_EGR, data, err);
    check_data("egr_reads_zero", '0, data);
    apb_write(ADDR_CNT, 32'h55);
    apb_read(ADDR_CNT, data, err);
    check_data("cnt_ignores_write", '0, data);
    apb_read(8'h08, data, err);
    check_bit("unmapped_pslverr", 1'b1, err);

    // UG with the counter stopped
    apb_write(ADDR_ARR, 32'h20);
    apb_write(ADDR_CR1, 32'h1 << CR1_DIR);
    apb_write(ADDR_EGR, 32'h1);
    apb_read(ADDR_CNT, data, err);
    check_data("ug_down_cnt", 32'h20, data);
    apb_read(ADDR_SR, data, err);
    check_data("ug_uif_set", 32'h1, data & 32'h1);
    apb_write(ADDR_SR, '0);
    apb_read(ADDR_SR, data, err);
    check_data("uif_cleared", '0, data & 32'h1);
    apb_write(ADDR_CR1, '0);
    apb_write(ADDR_EGR, 32'h1);
    apb_read(ADDR_CNT, data, err);
    check_data("ug_up_cnt", '0, data);

    for (int r = 0; r < ROWS; r++) begin
      run_row(table_q[r], r % CH_NUM);
    end

    // UIF is pending from the runs above
    apb_write(ADDR_CR1, '0);
    apb_write(ADDR_DIER, 32'h1);
    idle(3);
    check_bit("irq_uie", 1'b1, irq);
    apb_write(ADDR_DIER, '0);

    // One-pulse mode
    apb_write(ADDR_CCER, '0);
    start_counter(0, 5, 1'b0, 1'b1);
    pulses = 0;
    repeat (40) begin
      @(negedge aclk);
      pulses += int'(trg);
    end
    check_data("opm_pulses", 32'd1, reg_data_t'(pulses));
    apb_read(ADDR_CR1, data, err);
    check_data("opm_cen_cleared", '0, data & 32'h1);

    // Compare flags
    for (int i = 0; i < CH_NUM; i++) begin
      apb_write(ADDR_CCR1 + reg_addr_t'(4 * i), reg_data_t'(i + 1));
    end
    apb_write(ADDR_PSC, '0);
    apb_write(ADDR_ARR, 32'd7);
    apb_write(ADDR_EGR, 32'h1);
    apb_write(ADDR_SR, '0);
    apb_write(ADDR_CR1, 32'h1);
    idle(14);
    apb_write(ADDR_CR1, '0);
    apb_read(ADDR_SR, data, err);
    check_data("ccif_all", 32'h1e, data & 32'h1e);
    apb_write(ADDR_DIER, 32'h2);
    idle(3);
    check_bit("irq_cc1ie", 1'b1, irq);
    apb_write(ADDR_SR, 32'hffff_fffd);
    idle(3);
    check_bit("irq_cc1_cleared", 1'b0, irq);

    $display("%0d checks, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hw/gpt_reg_pkg.sv
hw/gpt_tim_pkg.sv
hw/gpt_apb_regs.sv
hw/gpt_time_base.sv
hw/gpt_oc_channel.sv
hw/gpt_top.sv
tb/gpt_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module gpt_tb -f tb.f -o gpt_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/gpt_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
